// File: common/mmio_params.svh
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// Packet lengths in bytes
`define MMIO_CMD_BYTES 8
`define MMIO_RESP_BYTES 3

// Command codes, byte 0 of the command packet
`define MMIO_CODE_SET 8'h01
`define MMIO_CODE_GET 8'h02
`define MMIO_CODE_QUERY 8'h03

// Response status codes
`define MMIO_ST_OK 4'd0
`define MMIO_ST_BUS_ERR 4'd1
`define MMIO_ST_BAD_CMD 4'd2

`define MMIO_DEVICE_ID 16'h5A11  // Returned by QUERY

`endif

// File: common/mmio_pkg.sv
package mmio_pkg;

  // One byte on either USB stream
  typedef logic [7:0] usb_byte_t;

  // Host-chosen tag, echoed back in byte 0 of the response
  typedef logic [3:0] cmd_tag_t;

  // APB address and data
  typedef logic [31:0] mmio_addr_t;
  typedef logic [15:0] mmio_val_t;

  typedef logic [7:0] cmd_code_t;  // Byte 0 of a command packet

  typedef logic [3:0] resp_status_t;  // Upper nibble of response byte 0

  // One-command sequencer in the top level
  // HALT until both endpoints are configured, then one command at a time
  typedef enum logic [1:0] {
    ST_HALT,  // Endpoints not configured
    ST_IDLE,  // Waiting for a decoded command
    ST_EXEC,  // APB transfer in flight
    ST_RESP   // Response being streamed out
  } seq_state_t;

endpackage

// File: rtl/cmd_to_apb.sv
`timescale 1ns/10ps

module cmd_to_apb (
  input  logic                  clock,
  input  logic                  areset_n,
  input  logic                  apb_start_i,
  input  logic                  apb_write_i,
  input  mmio_pkg::mmio_addr_t  apb_adr_i,
  input  mmio_pkg::mmio_val_t   apb_wdata_i,
  output logic                  apb_done_o,
  output logic                  apb_err_o,
  output mmio_pkg::mmio_val_t   apb_rdata_o,
  output logic                  psel_o,
  output logic                  penable_o,
  output logic                  pwrite_o,
  output logic [1:0]            pstrb_o,
  output mmio_pkg::mmio_addr_t  paddr_o,
  output mmio_pkg::mmio_val_t   pwdata_o,
  input  logic                  pready_i,
  input  logic                  pslverr_i,
  input  mmio_pkg::mmio_val_t   prdata_i
);

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_t;

  apb_state_t state_q;
  logic launch, finish;

  assign launch = (state_q == APB_IDLE) && apb_start_i;
  assign finish = (state_q == APB_ACCESS) && pready_i;

  assign psel_o    = state_q != APB_IDLE;
  assign penable_o = state_q == APB_ACCESS;
  assign pstrb_o   = pwrite_o ? 2'b11 : 2'b00;  // Full 16-bit writes only

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q    <= APB_IDLE;
      apb_done_o <= 1'b0;
      apb_err_o  <= 1'b0;
      pwrite_o   <= 1'b0;
    end else begin
      apb_done_o <= 1'b0;
      case (state_q)
        APB_IDLE: begin
          if (apb_start_i) begin
            state_q  <= APB_SETUP;
            pwrite_o <= apb_write_i;
          end
        end
        APB_SETUP: state_q <= APB_ACCESS;  // Always a single cycle
        APB_ACCESS: begin
          if (pready_i) begin
            state_q    <= APB_IDLE;
            apb_done_o <= 1'b1;
            apb_err_o  <= pslverr_i;
          end
        end
        default: state_q <= APB_IDLE;
      endcase
    end
  end

  // Address and write data held through wait states
  always_ff @(posedge clock) begin
    if (launch) begin
      paddr_o  <= apb_adr_i;
      pwdata_o <= apb_wdata_i;
    end
    if (finish) apb_rdata_o <= prdata_i;
  end

endmodule

// File: ep_out/mmio_ep_out.sv
`timescale 1ns/10ps
`include "mmio_params.svh"

module mmio_ep_out (
  input  logic                  clock,
  input  logic                  areset_n,
  input  logic                  enable_i,
  input  logic                  cmd_busy_i,
  input  logic                  usb_tvalid_i,
  output logic                  usb_tready_o,
  input  logic                  usb_tlast_i,
  input  mmio_pkg::usb_byte_t   usb_tdata_i,
  output logic                  cmd_vld_o,
  output logic                  cmd_bad_o,
  output mmio_pkg::cmd_code_t   cmd_code_o,
  output mmio_pkg::cmd_tag_t    cmd_tag_o,
  output mmio_pkg::mmio_addr_t  cmd_adr_o,
  output mmio_pkg::mmio_val_t   cmd_val_o
);

  logic [3:0] cnt_q;  // Byte position in the current packet, saturates past the end
  logic len_err_q;
  logic accept, last_byte, code_known;

  // Hold off from the cmd_vld cycle until the sequencer takes over with busy
  assign usb_tready_o = enable_i && !cmd_busy_i && !cmd_vld_o;
  assign accept       = usb_tvalid_i && usb_tready_o;
  assign last_byte    = cnt_q == 4'(`MMIO_CMD_BYTES - 1);

  assign code_known = (cmd_code_o == `MMIO_CODE_SET) ||
                      (cmd_code_o == `MMIO_CODE_GET) ||
                      (cmd_code_o == `MMIO_CODE_QUERY);
  assign cmd_bad_o  = len_err_q || !code_known;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      cnt_q     <= 4'd0;
      cmd_vld_o <= 1'b0;
      len_err_q <= 1'b0;
    end else begin
      cmd_vld_o <= 1'b0;
      if (!enable_i) begin
        cnt_q <= 4'd0;  // Drop any partial packet
      end else if (accept) begin
        if (usb_tlast_i) begin
          cnt_q     <= 4'd0;
          cmd_vld_o <= 1'b1;
          len_err_q <= !last_byte;  // Short or long packet
        end else if (cnt_q != 4'(`MMIO_CMD_BYTES)) begin
          cnt_q <= cnt_q + 4'd1;
        end
      end
    end
  end

  // Field capture, address and value arrive LSB first
  always_ff @(posedge clock) begin
    if (accept) begin
      case (cnt_q)
        4'd0: cmd_code_o        <= usb_tdata_i;
        4'd1: cmd_tag_o         <= usb_tdata_i[3:0];  // Upper nibble ignored
        4'd2: cmd_adr_o[7:0]    <= usb_tdata_i;
        4'd3: cmd_adr_o[15:8]   <= usb_tdata_i;
        4'd4: cmd_adr_o[23:16]  <= usb_tdata_i;
        4'd5: cmd_adr_o[31:24]  <= usb_tdata_i;
        4'd6: cmd_val_o[7:0]    <= usb_tdata_i;
        4'd7: cmd_val_o[15:8]   <= usb_tdata_i;
        default: ;  // Extra bytes of a long packet are drained
      endcase
    end
  end

endmodule

// File: ep_in/mmio_ep_in.sv
`timescale 1ns/10ps
`include "mmio_params.svh"

module mmio_ep_in (
  input  logic                    clock,
  input  logic                    areset_n,
  input  logic                    resp_send_i,
  input  mmio_pkg::cmd_tag_t      resp_tag_i,
  input  mmio_pkg::resp_status_t  resp_status_i,
  input  mmio_pkg::mmio_val_t     resp_val_i,
  output logic                    resp_done_o,
  output logic                    usb_tvalid_o,
  input  logic                    usb_tready_i,
  output logic                    usb_tlast_o,
  output mmio_pkg::usb_byte_t     usb_tdata_o
);

  import mmio_pkg::*;

  usb_byte_t resp_q [`MMIO_RESP_BYTES];  // Framed response packet
  logic [1:0] idx_q;
  logic accept, last_idx;

  assign accept   = usb_tvalid_o && usb_tready_i;
  assign last_idx = idx_q == 2'(`MMIO_RESP_BYTES - 1);

  assign usb_tdata_o = resp_q[idx_q];
  assign usb_tlast_o = usb_tvalid_o && last_idx;
  assign resp_done_o = accept && last_idx;  // Final byte taken by the host

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      usb_tvalid_o <= 1'b0;
      idx_q        <= 2'd0;
    end else if (resp_send_i) begin
      usb_tvalid_o <= 1'b1;
      idx_q        <= 2'd0;
    end else if (accept) begin
      if (last_idx) begin
        usb_tvalid_o <= 1'b0;
      end else begin
        idx_q <= idx_q + 2'd1;  // Step only on a handshake
      end
    end
  end

  // Status and tag share byte 0, value follows LSB first
  always_ff @(posedge clock) begin
    if (resp_send_i) begin
      resp_q[0] <= {resp_status_i, resp_tag_i};
      resp_q[1] <= resp_val_i[7:0];
      resp_q[2] <= resp_val_i[15:8];
    end
  end

endmodule

// File: rtl/usb_mmio.sv
`timescale 1ns/10ps
`include "mmio_params.svh"

module usb_mmio (
  input  logic                  clock,
  input  logic                  areset_n,
  input  logic                  epo_set_conf_i,
  input  logic                  epo_clr_conf_i,
  input  logic                  epi_set_conf_i,
  input  logic                  epi_clr_conf_i,
  input  logic                  usb_tvalid_i,
  output logic                  usb_tready_o,
  input  logic                  usb_tlast_i,
  input  mmio_pkg::usb_byte_t   usb_tdata_i,
  output logic                  usb_tvalid_o,
  input  logic                  usb_tready_i,
  output logic                  usb_tlast_o,
  output mmio_pkg::usb_byte_t   usb_tdata_o,
  output logic                  psel_o,
  output logic                  penable_o,
  output logic                  pwrite_o,
  output logic [1:0]            pstrb_o,
  output mmio_pkg::mmio_addr_t  paddr_o,
  output mmio_pkg::mmio_val_t   pwdata_o,
  input  logic                  pready_i,
  input  logic                  pslverr_i,
  input  mmio_pkg::mmio_val_t   prdata_i
);

  import mmio_pkg::*;

  logic epo_en_q, epi_en_q;
  seq_state_t state_q;
  logic apb_start_q, resp_send_q;
  resp_status_t resp_status_q;
  mmio_val_t resp_val_q;

  logic cmd_vld, cmd_bad, cmd_busy, cmd_direct, cmd_write, ep_enable;
  cmd_code_t cmd_code;
  cmd_tag_t cmd_tag;
  mmio_addr_t cmd_adr;
  mmio_val_t cmd_val;
  logic apb_done, apb_err, resp_done;
  mmio_val_t apb_rdata;

  assign ep_enable  = epo_en_q && epi_en_q;
  assign cmd_busy   = state_q != ST_IDLE;  // Also covers HALT
  assign cmd_direct = cmd_bad || (cmd_code == `MMIO_CODE_QUERY);  // No bus access needed
  assign cmd_write  = cmd_code == `MMIO_CODE_SET;

  // Endpoint configuration, set wins over clear
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      epo_en_q <= 1'b0;
      epi_en_q <= 1'b0;
    end else begin
      if (epo_set_conf_i) epo_en_q <= 1'b1;
      else if (epo_clr_conf_i) epo_en_q <= 1'b0;
      if (epi_set_conf_i) epi_en_q <= 1'b1;
      else if (epi_clr_conf_i) epi_en_q <= 1'b0;
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q     <= ST_HALT;
      apb_start_q <= 1'b0;
      resp_send_q <= 1'b0;
    end else begin
      apb_start_q <= 1'b0;
      resp_send_q <= 1'b0;
      if (epo_clr_conf_i || epi_clr_conf_i) begin
        state_q <= ST_HALT;
      end else begin
        case (state_q)
          ST_HALT: if (ep_enable) state_q <= ST_IDLE;
          ST_IDLE: begin
            if (cmd_vld && cmd_direct) begin
              state_q     <= ST_RESP;
              resp_send_q <= 1'b1;  // QUERY or error, answer at once
            end else if (cmd_vld) begin
              state_q     <= ST_EXEC;
              apb_start_q <= 1'b1;
            end
          end
          ST_EXEC: begin
            if (apb_done) begin
              state_q     <= ST_RESP;
              resp_send_q <= 1'b1;
            end
          end
          ST_RESP: if (resp_done) state_q <= ST_IDLE;
          default: state_q <= ST_HALT;
        endcase
      end
    end
  end

  // Response fields, loaded with the resp_send pulse
  always_ff @(posedge clock) begin
    if (state_q == ST_IDLE && cmd_vld && cmd_direct) begin
      resp_status_q <= cmd_bad ? `MMIO_ST_BAD_CMD : `MMIO_ST_OK;
      resp_val_q    <= cmd_bad ? 16'h0000 : `MMIO_DEVICE_ID;
    end else if (state_q == ST_EXEC && apb_done) begin
      resp_status_q <= apb_err ? `MMIO_ST_BUS_ERR : `MMIO_ST_OK;
      resp_val_q    <= (apb_err || cmd_write) ? 16'h0000 : apb_rdata;
    end
  end

  mmio_ep_out i_ep_out (
    .clock        (clock),
    .areset_n     (areset_n),
    .enable_i     (ep_enable),
    .cmd_busy_i   (cmd_busy),
    .usb_tvalid_i (usb_tvalid_i),
    .usb_tready_o (usb_tready_o),
    .usb_tlast_i  (usb_tlast_i),
    .usb_tdata_i  (usb_tdata_i),
    .cmd_vld_o    (cmd_vld),
    .cmd_bad_o    (cmd_bad),
    .cmd_code_o   (cmd_code),
    .cmd_tag_o    (cmd_tag),
    .cmd_adr_o    (cmd_adr),
    .cmd_val_o    (cmd_val)
  );

  cmd_to_apb i_apb (
    .clock       (clock),
    .areset_n    (areset_n),
    .apb_start_i (apb_start_q),
    .apb_write_i (cmd_write),
    .apb_adr_i   (cmd_adr),
    .apb_wdata_i (cmd_val),
    .apb_done_o  (apb_done),
    .apb_err_o   (apb_err),
    .apb_rdata_o (apb_rdata),
    .psel_o      (psel_o),
    .penable_o   (penable_o),
    .pwrite_o    (pwrite_o),
    .pstrb_o     (pstrb_o),
    .paddr_o     (paddr_o),
    .pwdata_o    (pwdata_o),
    .pready_i    (pready_i),
    .pslverr_i   (pslverr_i),
    .prdata_i    (prdata_i)
  );

  mmio_ep_in i_ep_in (
    .clock         (clock),
    .areset_n      (areset_n),
    .resp_send_i   (resp_send_q),
    .resp_tag_i    (cmd_tag),  // Stable until the next packet is accepted
    .resp_status_i (resp_status_q),
    .resp_val_i    (resp_val_q),
    .resp_done_o   (resp_done),
    .usb_tvalid_o  (usb_tvalid_o),
    .usb_tready_i  (usb_tready_i),
    .usb_tlast_o   (usb_tlast_o),
    .usb_tdata_o   (usb_tdata_o)
  );

endmodule

// File: verification/usb_mmio_chk.sv
`timescale 1ns/10ps

module usb_mmio_chk (
  input logic                  clock,
  input logic                  areset_n,
  input logic                  psel_o,
  input logic                  penable_o,
  input logic                  pwrite_o,
  input mmio_pkg::mmio_addr_t  paddr_o,
  input mmio_pkg::mmio_val_t   pwdata_o,
  input logic                  pready_i,
  input logic                  usb_tvalid_o,
  input logic                  usb_tready_i,
  input logic                  usb_tlast_o,
  input mmio_pkg::usb_byte_t   usb_tdata_o,
  input logic                  usb_tready_o,
  input mmio_pkg::seq_state_t  state_q
);

  import mmio_pkg::*;

  // Bus fields frozen from setup until the completing access cycle
  a_apb_stable: assert property (@(posedge clock) disable iff (!areset_n)
    psel_o && !(penable_o && pready_i) |=>
      $stable(paddr_o) && $stable(pwrite_o) && $stable(pwdata_o))
    else $error("APB address, direction or write data changed during a transfer");

  a_apb_setup: assert property (@(posedge clock) disable iff (!areset_n)
    $rose(penable_o) |-> psel_o && $past(psel_o) && !$past(psel_o, 2))
    else $error("penable did not follow a single-cycle setup phase");

  a_resp_hold: assert property (@(posedge clock) disable iff (!areset_n)
    usb_tvalid_o && !usb_tready_i |=>
      usb_tvalid_o && $stable(usb_tdata_o) && $stable(usb_tlast_o))
    else $error("response byte changed while stalled");

  a_cmd_gate: assert property (@(posedge clock) disable iff (!areset_n)
    state_q != ST_IDLE |-> !usb_tready_o)  // One command in flight
    else $error("command stream ready outside IDLE");

endmodule

bind usb_mmio usb_mmio_chk i_chk (
  .clock        (clock),
  .areset_n     (areset_n),
  .psel_o       (psel_o),
  .penable_o    (penable_o),
  .pwrite_o     (pwrite_o),
  .paddr_o      (paddr_o),
  .pwdata_o     (pwdata_o),
  .pready_i     (pready_i),
  .usb_tvalid_o (usb_tvalid_o),
  .usb_tready_i (usb_tready_i),
  .usb_tlast_o  (usb_tlast_o),
  .usb_tdata_o  (usb_tdata_o),
  .usb_tready_o (usb_tready_o),
  .state_q      (state_q)
);

// File: verification/usb_mmio_tb.sv
`timescale 1ns/10ps
`include "mmio_params.svh"

module usb_mmio_tb;

  import mmio_pkg::*;

  localparam int MAX_TESTS = 32;
  localparam string DATA_FILE = "verification/usb_mmio_testdata.txt";

  logic clock = 1'b0;
  logic areset_n, epo_set_conf_i, epo_clr_conf_i, epi_set_conf_i, epi_clr_conf_i;
  logic usb_tvalid_i, usb_tready_o, usb_tlast_i, usb_tvalid_o, usb_tready_i, usb_tlast_o;
  usb_byte_t usb_tdata_i, usb_tdata_o;
  logic psel_o, penable_o, pwrite_o, pready_i, pslverr_i;
  logic [1:0] pstrb_o;
  mmio_addr_t paddr_o;
  mmio_val_t pwdata_o, prdata_i;

  // One entry per line of the test data file
  string t_name [MAX_TESTS];
  int t_len [MAX_TESTS];
  int t_acc [MAX_TESTS];  // 0 none, 1 read, 2 write
  usb_byte_t t_cmd [MAX_TESTS][`MMIO_CMD_BYTES];
  mmio_addr_t t_adr [MAX_TESTS];
  mmio_val_t t_wdata [MAX_TESTS], t_rdata [MAX_TESTS];
  logic t_slverr [MAX_TESTS];
  usb_byte_t t_resp [MAX_TESTS][`MMIO_RESP_BYTES];

  int n_tests = 0, cur = 0, errors = 0, cycle_cnt = 0, cycle_limit = 0;
  int apb_count = 0, apb_waits = 0;
  string test_name = "reset";
  usb_byte_t resp_data [$];  // Bytes seen on the response stream
  logic resp_last [$];

  always #50 clock = ~clock;

  usb_mmio i_dut (.*);

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("mismatch in %s, %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic end_run;
    $display("tests: %0d, errors: %0d", n_tests, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  endtask

  // APB completer with 0 to 3 wait states per access
  task automatic apb_step;
    pready_i  = 1'b0;
    pslverr_i = 1'b0;
    prdata_i  = 16'($urandom);  // Junk outside the ready cycle
    if (psel_o && !penable_o) begin
      apb_count++;
      apb_waits = int'($urandom % 32'd4);
      if (t_acc[cur] == 0) begin
        errors++;
        $display("%s: unexpected APB access at address %h", test_name, paddr_o);
      end else begin
        check_value("pwrite", 32'(t_acc[cur] == 2), 32'(pwrite_o));
        check_value("paddr", t_adr[cur], paddr_o);
        check_value("pstrb", (t_acc[cur] == 2) ? 32'h3 : 32'h0, 32'(pstrb_o));
        if (t_acc[cur] == 2)
          check_value("pwdata", 32'(t_wdata[cur]), 32'(pwdata_o));
      end
    end else if (psel_o && penable_o) begin
      if (apb_waits == 0) begin
        pready_i  = 1'b1;
        pslverr_i = t_slverr[cur];
        prdata_i  = t_rdata[cur];
      end else begin
        apb_waits--;
      end
    end
  endtask

  // Response sink logs a byte that transfers on the next rising edge
  task automatic sink_step;
    usb_tready_i = ($urandom % 32'd4) != 32'd0;  // Stall about one cycle in four
    if (usb_tvalid_o && usb_tready_i) begin
      resp_data.push_back(usb_tdata_o);
      resp_last.push_back(usb_tlast_o);
    end
  endtask

  // One clock cycle of the completer and sink models
  task automatic tick;
    @(negedge clock);
    apb_step();
    sink_step();
  endtask

  task automatic send_packet(input int idx);
    logic taken;
    for (int b = 0; b < t_len[idx]; b++) begin
      usb_tvalid_i = 1'b1;
      usb_tlast_i  = b == t_len[idx] - 1;
      usb_tdata_i  = (b < `MMIO_CMD_BYTES) ? t_cmd[idx][b] : 8'hee;  // Pad of a long packet
      do begin
        taken = usb_tready_o;  // Stable until the next rising edge
        tick();
      end while (!taken);
    end
    usb_tvalid_i = 1'b0;
    usb_tlast_i  = 1'b0;
  endtask

  task automatic load_tests;
    int fd;
    int n;
    int f [17];
    string line;
    string nm;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open test data file %s", DATA_FILE);
    end else begin
      while ($fgets(line, fd) != 0 && n_tests < MAX_TESTS) begin
        if (line.len() > 1 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %d %h %h %h %d %h %h %h",
                      nm, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                      f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
          if (n != 18) begin
            errors++;
            $display("test data line could not be read: %s", line);
          end else begin
            t_name[n_tests] = nm;
            t_len[n_tests]  = f[0];
            for (int j = 0; j < `MMIO_CMD_BYTES; j++)
              t_cmd[n_tests][j] = 8'(f[1 + j]);
            t_acc[n_tests]    = f[9];
            t_adr[n_tests]    = f[10];
            t_wdata[n_tests]  = 16'(f[11]);
            t_rdata[n_tests]  = 16'(f[12]);
            t_slverr[n_tests] = f[13][0];
            for (int j = 0; j < `MMIO_RESP_BYTES; j++)
              t_resp[n_tests][j] = 8'(f[14 + j]);
            n_tests++;
          end
        end
      end
      $fclose(fd);
      if (n_tests == 0) begin
        errors++;
        $display("no tests found in %s", DATA_FILE);
      end
    end
  endtask

  // Cycle limit on the whole run
  initial begin
    do begin
      @(negedge clock);
      cycle_cnt++;
    end while (cycle_cnt <= cycle_limit);
    errors++;
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    end_run();
  end

  initial begin
    void'($urandom(2124));
    areset_n       = 1'b0;
    epo_set_conf_i = 1'b0;
    epo_clr_conf_i = 1'b0;
    epi_set_conf_i = 1'b0;
    epi_clr_conf_i = 1'b0;
    usb_tvalid_i   = 1'b0;
    usb_tlast_i    = 1'b0;
    usb_tdata_i    = 8'h00;
    usb_tready_i   = 1'b0;
    pready_i       = 1'b0;
    pslverr_i      = 1'b0;
    prdata_i       = 16'h0000;
    load_tests();
    cycle_limit = 200 * n_tests + 100;
    repeat (4) tick();
    areset_n = 1'b1;

    // A byte waits while the endpoints are still unconfigured
    test_name    = "pre_config";
    usb_tvalid_i = 1'b1;
    usb_tdata_i  = `MMIO_CODE_GET;
    repeat (8) begin
      check_value("usb_tready_o", 32'd0, 32'(usb_tready_o));
      tick();
    end
    usb_tvalid_i   = 1'b0;
    epo_set_conf_i = 1'b1;
    epi_set_conf_i = 1'b1;
    tick();
    epo_set_conf_i = 1'b0;
    epi_set_conf_i = 1'b0;
    repeat (2) tick();

    for (int i = 0; i < n_tests; i++) begin
      cur       = i;
      test_name = t_name[i];
      apb_count = 0;
      resp_data.delete();
      resp_last.delete();
      send_packet(i);
      while (resp_data.size() < `MMIO_RESP_BYTES)
        tick();
      tick();  // Last byte's handshake
      check_value("response length", 32'(`MMIO_RESP_BYTES), 32'(resp_data.size()));
      for (int j = 0; j < `MMIO_RESP_BYTES; j++) begin
        check_value($sformatf("response byte %0d", j), 32'(t_resp[i][j]), 32'(resp_data[j]));
        check_value($sformatf("tlast on byte %0d", j), 32'(j == `MMIO_RESP_BYTES - 1),
                    32'(resp_last[j]));
      end
      check_value("APB accesses", 32'(t_acc[i] != 0), 32'(apb_count));
    end
    end_run();
  end

endmodule

// File: verification/usb_mmio_testdata.txt
# name len c0..c7 (hex) apb(0 none, 1 read, 2 write) addr wdata prdata pslverr (hex)
# then the three expected response bytes (hex); bytes past c7 of a long packet are sent as ee
set_basic         8 01 03 10 00 00 40 34 12  2 40000010 1234 0000 0  03 00 00
get_basic         8 02 05 20 00 00 40 00 00  1 40000020 0000 beef 0  05 ef be
query             8 03 07 00 00 00 00 00 00  0 00000000 0000 0000 0  07 11 5a
set_tag_hi        8 01 a6 04 30 00 80 cd ab  2 80003004 abcd 0000 0  06 00 00
get_slverr        8 02 0a 08 00 01 00 00 00  1 00010008 0000 1357 1  1a 00 00
set_slverr        8 01 0c 0c 00 01 00 55 aa  2 0001000c aa55 0000 1  1c 00 00
short6            6 02 04 00 01 00 00 00 00  0 00000000 0000 0000 0  24 00 00
get_after_short   8 02 0d 00 01 00 00 00 00  1 00000100 0000 4c21 0  0d 21 4c
long9             9 01 06 00 02 00 00 11 22  0 00000000 0000 0000 0  26 00 00
query_after_long  8 03 08 00 00 00 00 00 00  0 00000000 0000 0000 0  08 11 5a
bad_code          8 7f 0b 00 00 00 00 00 00  0 00000000 0000 0000 0  2b 00 00
set_after_bad     8 01 0e 40 00 00 c0 78 56  2 c0000040 5678 0000 0  0e 00 00
short2            2 02 05 00 00 00 00 00 00  0 00000000 0000 0000 0  25 00 00
code_zero         8 00 01 00 00 00 00 00 00  0 00000000 0000 0000 0  21 00 00
long12           12 02 07 00 00 00 00 00 00  0 00000000 0000 0000 0  27 00 00
get_after_long    8 02 02 00 10 00 00 00 00  1 00001000 0000 0f0e 0  02 0e 0f
get_zero_tag      8 02 00 fc ff ff ff 00 00  1 fffffffc 0000 ffff 0  00 ff ff
set_max           8 01 0f fe ff 00 00 ff ff  2 0000fffe ffff 0000 0  0f 00 00
get_bp1           8 02 01 10 20 30 40 00 00  1 40302010 0000 0102 0  01 02 01
get_bp2           8 02 02 11 21 31 41 00 00  1 41312111 0000 a5c3 0  02 c3 a5
set_bp3           8 01 03 12 22 32 42 9a 78  2 42322212 789a 0000 0  03 00 00
get_slverr_bp     8 02 0e 14 00 00 00 00 00  1 00000014 0000 7777 1  1e 00 00
query_end         8 03 09 00 00 00 00 00 00  0 00000000 0000 0000 0  09 11 5a

// File: usb_mmio.f
+incdir+common
common/mmio_pkg.sv
rtl/cmd_to_apb.sv
ep_out/mmio_ep_out.sv
ep_in/mmio_ep_in.sv
rtl/usb_mmio.sv
verification/usb_mmio_chk.sv
verification/usb_mmio_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the usb_mmio testbench with Verilator and runs it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

log=sim.log

verilator --binary --timing --assert -j 0 --top-module usb_mmio_tb -f usb_mmio.f -o usb_mmio_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/usb_mmio_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

grep -qx "PASS: all tests" "$log"
if [ $? -ne 0 ]; then
  echo "pass message not found in $log"
  exit 1
fi
exit 0
